// ==== vlog.f ====
common/rvv_disp_pkg.sv
common/rvv_if.sv
rob/rvv_rob.sv
dispatch/rvv_dispatch_raw.sv
dispatch/rvv_dispatch_bypass.sv
dispatch/rvv_dispatch.sv
logic/rvv_vrf.sv
logic/rvv_vrf_wr_arb.sv
logic/rvv_backend_top.sv
dv/tb_rvv_backend.sv

// ==== Bender.yml ====
package:
  name: rvv_backend

sources:
  - common/rvv_disp_pkg.sv
  - common/rvv_if.sv
  - rob/rvv_rob.sv
  - dispatch/rvv_dispatch_raw.sv
  - dispatch/rvv_dispatch_bypass.sv
  - dispatch/rvv_dispatch.sv
  - logic/rvv_vrf.sv
  - logic/rvv_vrf_wr_arb.sv
  - logic/rvv_backend_top.sv
  - target: test
    files:
      - dv/tb_rvv_backend.sv

// ==== dv/tb_rvv_backend.sv ====
/*
 * testbench for the vector backend slice
 * table-driven stimulus against a shadow VRF and ROB model
 */
module tb_rvv_backend;
    timeunit 1ns;
    timeprecision 1ps;
    import rvv_disp_pkg::*;

    // row operation flags that may be combined
    localparam int OP_IDLE  = 0;
    localparam int OP_HOST  = 1;
    localparam int OP_ALLOC = 2;
    localparam int OP_WB    = 4;
    localparam int OP_REQ   = 8;
    localparam int OP_RMASK = 16;   // alloc mask from the LFSR

    typedef struct packed {
        logic [4:0] op;
        vreg_idx_t  a;      // host addr, alloc vd or vs1
        vreg_idx_t  b;      // vs2
        vreg_idx_t  c;      // vd
        logic [5:0] n;      // allocation number for writeback
        vl_t        vl;
        byte_mask_t mask;
        logic       vta;
        logic       vma;
        logic       stall;  // expected opn_stall
    } row_t;

    logic       clk;
    logic       rst;
    logic       alloc_valid;
    vreg_idx_t  alloc_vd;
    vl_t        alloc_vl;
    byte_mask_t alloc_mask;
    logic       alloc_vta;
    logic       alloc_vma;
    logic       alloc_ready;
    rob_idx_t   alloc_idx;
    logic       wb_valid;
    rob_idx_t   wb_idx;
    vreg_t      wb_data;
    logic       host_wr_req;
    vreg_idx_t  host_wr_addr;
    vreg_t      host_wr_data;
    logic       host_wr_gnt;
    logic       opn_req;
    vreg_idx_t  vs1_idx;
    vreg_idx_t  vs2_idx;
    vreg_idx_t  vd_idx;
    logic       opn_stall;
    logic       opn_valid;
    vreg_t      opn_vs1;
    vreg_t      opn_vs2;
    vreg_t      opn_vd;
    vreg_t      opn_v0;

    row_t        rows [$];
    int          limit;
    int          cycles;
    logic [15:0] lfsr;

    // shadow state with slots numbered as in the ROB
    vreg_t                m_vrf [NUM_VREG];
    vreg_idx_t            m_vd [ROB_DEPTH];
    vreg_t                m_data [ROB_DEPTH];
    vl_t                  m_vl [ROB_DEPTH];
    byte_mask_t           m_mask [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] m_done;
    logic [ROB_DEPTH-1:0] m_vta;
    logic [ROB_DEPTH-1:0] m_vma;
    int                   m_head;
    int                   m_tail;
    int                   m_count;
    rob_idx_t             slot_of [64];
    int                   n_alloc;
    logic                 exp_valid;
    vreg_t                exp_opn [4];

    rvv_backend_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic vreg_check(input string name, input vreg_t got, input vreg_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic slot_check(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic void add_row(input int op, a, b, c, n, vl, mask, vta, vma, stall);
        row_t r;
        r.op    = 5'(op);
        r.a     = vreg_idx_t'(a);
        r.b     = vreg_idx_t'(b);
        r.c     = vreg_idx_t'(c);
        r.n     = 6'(n);
        r.vl    = vl_t'(vl);
        r.mask  = byte_mask_t'(mask);
        r.vta   = (vta != 0);
        r.vma   = (vma != 0);
        r.stall = (stall != 0);
        rows.push_back(r);
    endfunction

    // youngest entry that writes the byte wins over the VRF byte
    function automatic vreg_t predict_operand(input vreg_idx_t r);
        vreg_t v;
        int    s;
        logic  found;
        v = m_vrf[r];
        for (int j = 0; j < VLENB; j++) begin
            found = 1'b0;
            for (int age = m_count - 1; age >= 0; age--) begin
                s = (m_head + age) % ROB_DEPTH;
                if (!found && m_vd[s] == r) begin
                    if (j >= m_vl[s]) begin
                        found = m_vta[s];
                        if (found) v[8*j+:8] = 8'hFF;
                    end else if (m_mask[s][j]) begin
                        found     = 1'b1;
                        v[8*j+:8] = m_data[s][8*j+:8];
                    end else begin
                        found = m_vma[s];
                        if (found) v[8*j+:8] = 8'hFF;
                    end
                end
            end
        end
        return v;
    endfunction

    task automatic advance_model(input row_t r, input vreg_t wdata, input vreg_t hdata);
        logic ret;
        int   s;
        ret = (m_count > 0) && m_done[m_head];
        if (ret)
            m_vrf[m_vd[m_head]] = m_data[m_head];
        if (r.op[1] && m_count != ROB_DEPTH) begin
            s                = m_tail;
            m_vd[s]          = r.a;
            m_vl[s]          = r.vl;
            m_mask[s]        = r.mask;
            m_vta[s]         = r.vta;
            m_vma[s]         = r.vma;
            m_done[s]        = 1'b0;
            slot_of[n_alloc] = rob_idx_t'(s);
            n_alloc++;
            m_tail  = (m_tail + 1) % ROB_DEPTH;
            m_count = m_count + 1;
        end
        if (r.op[2]) begin
            m_done[slot_of[r.n]] = 1'b1;
            m_data[slot_of[r.n]] = wdata;
        end
        if (ret) begin
            m_head  = (m_head + 1) % ROB_DEPTH;
            m_count = m_count - 1;
        end
        if (r.op[0] && !ret)
            m_vrf[r.a] = hdata;     // host wins only when retire is idle
    endtask

    task automatic verify_outputs();
        flag_check("opn_valid", opn_valid, exp_valid);
        if (exp_valid) begin
            vreg_check("opn_vs1", opn_vs1, exp_opn[0]);
            vreg_check("opn_vs2", opn_vs2, exp_opn[1]);
            vreg_check("opn_vd", opn_vd, exp_opn[2]);
            vreg_check("opn_v0", opn_v0, exp_opn[3]);
        end
    endtask

    task automatic apply_row(input row_t r);
        row_t  cur;
        vreg_t wdata;
        vreg_t hdata;
        vreg_t nxt [4];
        logic  done;
        logic  ret_busy;
        cur   = r;
        wdata = '0;
        hdata = '0;
        if (cur.op[4]) cur.mask = byte_mask_t'(rand_bits(VLENB));
        if (cur.op[2]) wdata = rand_bits(VLEN);
        if (cur.op[0]) hdata = rand_bits(VLEN);
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            verify_outputs();
            alloc_valid  = cur.op[1];
            alloc_vd     = cur.a;
            alloc_vl     = cur.vl;
            alloc_mask   = cur.mask;
            alloc_vta    = cur.vta;
            alloc_vma    = cur.vma;
            wb_valid     = cur.op[2];
            wb_idx       = slot_of[cur.n];
            wb_data      = wdata;
            host_wr_req  = cur.op[0];
            host_wr_addr = cur.a;
            host_wr_data = hdata;
            opn_req      = cur.op[3];
            vs1_idx      = cur.a;
            vs2_idx      = cur.b;
            vd_idx       = cur.c;
            #1;
            ret_busy = (m_count > 0) && m_done[m_head];
            flag_check("alloc_ready", alloc_ready, m_count != ROB_DEPTH);
            flag_check("host_wr_gnt", host_wr_gnt, cur.op[0] && !ret_busy);
            if (cur.op[1]) slot_check("alloc_idx", alloc_idx, rob_idx_t'(m_tail));
            if (cur.op[3]) flag_check("opn_stall", opn_stall, cur.stall);
            // requests hold until granted or accepted
            done   = !(cur.op[0] && !host_wr_gnt) && !(cur.op[1] && !alloc_ready);
            nxt[0] = predict_operand(cur.a);
            nxt[1] = predict_operand(cur.b);
            nxt[2] = predict_operand(cur.c);
            nxt[3] = predict_operand('0);
            @(posedge clk);
            advance_model(cur, wdata, hdata);
            exp_valid = cur.op[3] && !cur.stall;
            if (exp_valid) exp_opn = nxt;
        end
    endtask

    function automatic void build_table();
        // op, a, b, c, n, vl, mask, vta, vma, stall
        for (int r = 0; r < 4; r++) add_row(OP_HOST, r, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 1, 2, 3, 0, 0, 0, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // two producers of v5
        add_row(OP_HOST, 5, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_ALLOC, 5, 0, 0, 0, 4, 'hF, 0, 0, 0);
        add_row(OP_ALLOC, 5, 0, 0, 0, 4, 'hF, 0, 0, 0);
        add_row(OP_WB, 0, 0, 0, 1, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 5, 1, 5, 0, 0, 0, 0, 0, 0);
        add_row(OP_WB, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 5, 2, 5, 0, 0, 0, 0, 0, 0);     // both done
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 5, 5, 3, 0, 0, 0, 0, 0, 0);
        // agnostic and undisturbed tail and inactive bytes
        add_row(OP_HOST, 7, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_HOST, 8, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_ALLOC, 6, 0, 0, 0, 4, 'hF, 0, 0, 0);
        add_row(OP_ALLOC, 6, 0, 0, 0, 2, 'h1, 0, 0, 0);
        add_row(OP_ALLOC, 7, 0, 0, 0, 2, 'h1, 1, 1, 0);
        add_row(OP_ALLOC, 8, 0, 0, 0, 3, 'h5, 0, 0, 0);
        for (int n = 5; n >= 2; n--) add_row(OP_WB, 0, 0, 0, n, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 6, 7, 8, 0, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 6, 7, 8, 0, 0, 0, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // late producer of v0
        add_row(OP_ALLOC, 0, 0, 0, 0, 4, 'hF, 0, 0, 0);
        add_row(OP_REQ, 1, 2, 3, 0, 0, 0, 0, 0, 1);
        add_row(OP_REQ, 1, 2, 3, 0, 0, 0, 0, 0, 1);
        add_row(OP_REQ | OP_WB, 1, 2, 3, 6, 0, 0, 0, 0, 1);
        add_row(OP_REQ, 1, 2, 3, 0, 0, 0, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // retire holds off the host port
        add_row(OP_ALLOC, 9, 0, 0, 0, 4, 'hF, 0, 0, 0);
        add_row(OP_WB, 0, 0, 0, 7, 0, 0, 0, 0, 0);
        add_row(OP_HOST, 10, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 9, 10, 5, 0, 0, 0, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // fill the ROB past the wrap and drain it
        for (int i = 0; i < 8; i++) add_row(OP_ALLOC | OP_RMASK, 11 + i, 0, 0, 0, 4, 0, 1, 1, 0);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_WB, 0, 0, 0, 8, 0, 0, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_ALLOC | OP_RMASK, 19, 0, 0, 0, 4, 0, 1, 1, 0);
        for (int n = 16; n >= 10; n--) add_row(OP_WB, 0, 0, 0, n, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 13, 14, 19, 0, 0, 0, 0, 0, 0);  // random masks, head still pending
        add_row(OP_WB, 0, 0, 0, 9, 0, 0, 0, 0, 0);
        for (int i = 0; i < 8; i++) add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 11, 12, 13, 0, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 14, 15, 16, 0, 0, 0, 0, 0, 0);
        add_row(OP_REQ, 17, 18, 19, 0, 0, 0, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endfunction

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: run did not finish within %0d cycles", limit);
                fail_run();
            end
        end
    end

    initial begin
        rst          = 1'b1;
        alloc_valid  = 1'b0;
        alloc_vd     = '0;
        alloc_vl     = '0;
        alloc_mask   = '0;
        alloc_vta    = 1'b0;
        alloc_vma    = 1'b0;
        wb_valid     = 1'b0;
        wb_idx       = '0;
        wb_data      = '0;
        host_wr_req  = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        opn_req      = 1'b0;
        vs1_idx      = '0;
        vs2_idx      = '0;
        vd_idx       = '0;
        lfsr         = 16'd14713;
        m_head       = 0;
        m_tail       = 0;
        m_count      = 0;
        m_done       = '0;
        n_alloc      = 0;
        exp_valid    = 1'b0;
        foreach (m_vrf[r]) m_vrf[r] = '0;
        foreach (slot_of[i]) slot_of[i] = '0;
        build_table();
        limit = rows.size() * 8 + 50;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) apply_row(rows[i]);
        $display("test passed");
        $finish;
    end

endmodule

// ==== logic/rvv_backend_top.sv ====
/*
 * vector backend slice: ROB, dispatch with bypass, VRF and its write arbiter
 */
module rvv_backend_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc_valid,
    input  rvv_disp_pkg::vreg_idx_t  alloc_vd,
    input  rvv_disp_pkg::vl_t        alloc_vl,
    input  rvv_disp_pkg::byte_mask_t alloc_mask,
    input  logic                     alloc_vta,
    input  logic                     alloc_vma,
    output logic                     alloc_ready,
    output rvv_disp_pkg::rob_idx_t   alloc_idx,
    input  logic                     wb_valid,
    input  rvv_disp_pkg::rob_idx_t   wb_idx,
    input  rvv_disp_pkg::vreg_t      wb_data,
    input  logic                     host_wr_req,
    input  rvv_disp_pkg::vreg_idx_t  host_wr_addr,
    input  rvv_disp_pkg::vreg_t      host_wr_data,
    output logic                     host_wr_gnt,
    input  logic                     opn_req,
    input  rvv_disp_pkg::vreg_idx_t  vs1_idx,
    input  rvv_disp_pkg::vreg_idx_t  vs2_idx,
    input  rvv_disp_pkg::vreg_idx_t  vd_idx,
    output logic                     opn_stall,
    output logic                     opn_valid,
    output rvv_disp_pkg::vreg_t      opn_vs1,
    output rvv_disp_pkg::vreg_t      opn_vs2,
    output rvv_disp_pkg::vreg_t      opn_vd,
    output rvv_disp_pkg::vreg_t      opn_v0
);
    import rvv_disp_pkg::*;

    logic      vrf_we;
    vreg_idx_t vrf_waddr;
    vreg_t     vrf_wdata;

    rob_byp_if byp_if ();
    vrf_rd_if  rd_if ();
    vrf_wr_if  ret_if ();
    vrf_wr_if  host_if ();

    // host preload pins into the second write source
    assign host_if.req  = host_wr_req;
    assign host_if.addr = host_wr_addr;
    assign host_if.data = host_wr_data;
    assign host_wr_gnt  = host_if.gnt;

    rvv_rob u_rob (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_vd    (alloc_vd),
        .alloc_vl    (alloc_vl),
        .alloc_mask  (alloc_mask),
        .alloc_vta   (alloc_vta),
        .alloc_vma   (alloc_vma),
        .alloc_ready (alloc_ready),
        .alloc_idx   (alloc_idx),
        .wb_valid    (wb_valid),
        .wb_idx      (wb_idx),
        .wb_data     (wb_data),
        .byp         (byp_if.rob),
        .ret         (ret_if.src)
    );

    rvv_dispatch u_disp (
        .clk       (clk),
        .rst       (rst),
        .opn_req   (opn_req),
        .vs1_idx   (vs1_idx),
        .vs2_idx   (vs2_idx),
        .vd_idx    (vd_idx),
        .opn_stall (opn_stall),
        .opn_valid (opn_valid),
        .opn_vs1   (opn_vs1),
        .opn_vs2   (opn_vs2),
        .opn_vd    (opn_vd),
        .opn_v0    (opn_v0),
        .byp       (byp_if.disp),
        .rd        (rd_if.disp)
    );

    rvv_vrf_wr_arb u_arb (
        .ret   (ret_if.arb),
        .host  (host_if.arb),
        .we    (vrf_we),
        .waddr (vrf_waddr),
        .wdata (vrf_wdata)
    );

    rvv_vrf u_vrf (
        .clk   (clk),
        .rst   (rst),
        .rd    (rd_if.vrf),
        .we    (vrf_we),
        .waddr (vrf_waddr),
        .wdata (vrf_wdata)
    );

endmodule

// ==== logic/rvv_vrf_wr_arb.sv ====
/*
 * VRF write port arbiter, ROB retire has fixed priority over host preload
 */
module rvv_vrf_wr_arb (
    vrf_wr_if.arb                   ret,
    vrf_wr_if.arb                   host,
    output logic                    we,
    output rvv_disp_pkg::vreg_idx_t waddr,
    output rvv_disp_pkg::vreg_t     wdata
);

    assign ret.gnt  = ret.req;
    assign host.gnt = host.req && !ret.req;    // held off while retiring

    assign we    = ret.req || host.req;
    assign waddr = ret.req ? ret.addr : host.addr;
    assign wdata = ret.req ? ret.data : host.data;

endmodule

// ==== logic/rvv_vrf.sv ====
/*
 * vector register file, four combinational reads and one write port
 */
module rvv_vrf (
    input  logic                    clk,
    input  logic                    rst,
    vrf_rd_if.vrf                   rd,
    input  logic                    we,
    input  rvv_disp_pkg::vreg_idx_t waddr,
    input  rvv_disp_pkg::vreg_t     wdata
);
    import rvv_disp_pkg::*;

    vreg_t regs [NUM_VREG];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_VREG; r++) begin
                regs[r] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // no write-through, the ROB still holds the value in the write cycle
    assign rd.vs1_data = regs[rd.vs1_idx];
    assign rd.vs2_data = regs[rd.vs2_idx];
    assign rd.vd_data  = regs[rd.vd_idx];
    assign rd.v0_data  = regs[rd.v0_idx];

endmodule

// ==== dispatch/rvv_dispatch.sv ====
/*
 * dispatch stage: VRF reads, RAW check, bypass and registered operands
 */
module rvv_dispatch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    opn_req,
    input  rvv_disp_pkg::vreg_idx_t vs1_idx,
    input  rvv_disp_pkg::vreg_idx_t vs2_idx,
    input  rvv_disp_pkg::vreg_idx_t vd_idx,
    output logic                    opn_stall,
    output logic                    opn_valid,
    output rvv_disp_pkg::vreg_t     opn_vs1,
    output rvv_disp_pkg::vreg_t     opn_vs2,
    output rvv_disp_pkg::vreg_t     opn_vd,
    output rvv_disp_pkg::vreg_t     opn_v0,
    rob_byp_if.disp                 byp,
    vrf_rd_if.disp                  rd
);
    import rvv_disp_pkg::*;

    rob_vec_t vs1_hit, vs2_hit, vd_hit, v0_hit;
    vreg_t    sel_vs1, sel_vs2, sel_vd, sel_v0;
    logic     take;

    assign rd.vs1_idx = vs1_idx;
    assign rd.vs2_idx = vs2_idx;
    assign rd.vd_idx  = vd_idx;
    assign rd.v0_idx  = '0;         // mask register

    rvv_dispatch_raw u_raw (
        .byp     (byp),
        .vs1_idx (vs1_idx),
        .vs2_idx (vs2_idx),
        .vd_idx  (vd_idx),
        .vs1_hit (vs1_hit),
        .vs2_hit (vs2_hit),
        .vd_hit  (vd_hit),
        .v0_hit  (v0_hit),
        .stall   (opn_stall)
    );

    rvv_dispatch_bypass u_bypass (
        .byp     (byp),
        .vs1_hit (vs1_hit),
        .vs2_hit (vs2_hit),
        .vd_hit  (vd_hit),
        .v0_hit  (v0_hit),
        .vrf_vs1 (rd.vs1_data),
        .vrf_vs2 (rd.vs2_data),
        .vrf_vd  (rd.vd_data),
        .vrf_v0  (rd.v0_data),
        .opn_vs1 (sel_vs1),
        .opn_vs2 (sel_vs2),
        .opn_vd  (sel_vd),
        .opn_v0  (sel_v0)
    );

    assign take = opn_req && !opn_stall;

    always_ff @(posedge clk) begin
        if (rst)
            opn_valid <= 1'b0;
        else
            opn_valid <= take;  // one-cycle pulse
    end

    always_ff @(posedge clk) begin
        if (take) begin
            opn_vs1 <= sel_vs1;
            opn_vs2 <= sel_vs2;
            opn_vd  <= sel_vd;
            opn_v0  <= sel_v0;
        end
    end

endmodule

// ==== dispatch/rvv_dispatch_bypass.sv ====
/*
 * per-byte operand select from the ROB entries or the VRF
 * agnostic tail and inactive bytes read as all ones
 */
module rvv_dispatch_bypass (
    rob_byp_if.disp                byp,
    input  rvv_disp_pkg::rob_vec_t vs1_hit,
    input  rvv_disp_pkg::rob_vec_t vs2_hit,
    input  rvv_disp_pkg::rob_vec_t vd_hit,
    input  rvv_disp_pkg::rob_vec_t v0_hit,
    input  rvv_disp_pkg::vreg_t    vrf_vs1,
    input  rvv_disp_pkg::vreg_t    vrf_vs2,
    input  rvv_disp_pkg::vreg_t    vrf_vd,
    input  rvv_disp_pkg::vreg_t    vrf_v0,
    output rvv_disp_pkg::vreg_t    opn_vs1,
    output rvv_disp_pkg::vreg_t    opn_vs2,
    output rvv_disp_pkg::vreg_t    opn_vd,
    output rvv_disp_pkg::vreg_t    opn_v0
);
    import rvv_disp_pkg::*;

    // operand order: vs1, vs2, vd, v0
    rob_vec_t         hit [4];
    vreg_t            vrf_val [4];
    vreg_t            opn [4];
    logic [VLENB-1:0] agn [ROB_DEPTH];
    logic [VLENB-1:0] supply [ROB_DEPTH];

    assign hit[0] = vs1_hit;
    assign hit[1] = vs2_hit;
    assign hit[2] = vd_hit;
    assign hit[3] = v0_hit;

    assign vrf_val[0] = vrf_vs1;
    assign vrf_val[1] = vrf_vs2;
    assign vrf_val[2] = vrf_vd;
    assign vrf_val[3] = vrf_v0;

    // which entries write a given byte, and which of those fill with ones
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            for (int j = 0; j < VLENB; j++) begin
                agn[i][j] = (byp.byp_type[i][j] == BODY_INACTIVE && byp.byp_inactive_one[i]) ||
                            (byp.byp_type[i][j] == TAIL && byp.byp_tail_one[i]);
                supply[i][j] = (byp.byp_type[i][j] == BODY_ACTIVE) || agn[i][j];
            end
        end
    end

    for (genvar k = 0; k < 4; k++) begin : g_opn
        for (genvar j = 0; j < VLENB; j++) begin : g_byte
            rob_vec_t   sel;
            logic [7:0] pick;

            always_comb begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    sel[i] = hit[k][i] && supply[i][j];
                end
            end

            // youngest supplier first
            always_comb begin
                case (1'b1)
                    sel[7]:  pick = agn[7][j] ? 8'hFF : byp.byp_data[7][8*j+:8];
                    sel[6]:  pick = agn[6][j] ? 8'hFF : byp.byp_data[6][8*j+:8];
                    sel[5]:  pick = agn[5][j] ? 8'hFF : byp.byp_data[5][8*j+:8];
                    sel[4]:  pick = agn[4][j] ? 8'hFF : byp.byp_data[4][8*j+:8];
                    sel[3]:  pick = agn[3][j] ? 8'hFF : byp.byp_data[3][8*j+:8];
                    sel[2]:  pick = agn[2][j] ? 8'hFF : byp.byp_data[2][8*j+:8];
                    sel[1]:  pick = agn[1][j] ? 8'hFF : byp.byp_data[1][8*j+:8];
                    sel[0]:  pick = agn[0][j] ? 8'hFF : byp.byp_data[0][8*j+:8];
                    default: pick = vrf_val[k][8*j+:8];     // no producer in flight
                endcase
            end

            assign opn[k][8*j+:8] = pick;
        end
    end

    assign opn_vs1 = opn[0];
    assign opn_vs2 = opn[1];
    assign opn_vd  = opn[2];
    assign opn_v0  = opn[3];

endmodule

// ==== dispatch/rvv_dispatch_raw.sv ====
/*
 * RAW hazard check of dispatch operands against the ROB entries
 */
module rvv_dispatch_raw (
    rob_byp_if.disp                 byp,
    input  rvv_disp_pkg::vreg_idx_t vs1_idx,
    input  rvv_disp_pkg::vreg_idx_t vs2_idx,
    input  rvv_disp_pkg::vreg_idx_t vd_idx,
    output rvv_disp_pkg::rob_vec_t  vs1_hit,
    output rvv_disp_pkg::rob_vec_t  vs2_hit,
    output rvv_disp_pkg::rob_vec_t  vd_hit,
    output rvv_disp_pkg::rob_vec_t  v0_hit,
    output logic                    stall
);
    import rvv_disp_pkg::*;

    // true when the youngest hitting entry has no result yet
    function automatic logic youngest_pending(input rob_vec_t hit, input rob_vec_t done);
        logic pend;
        pend = 1'b0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (hit[i])
                pend = !done[i];    // later index is younger
        end
        return pend;
    endfunction

    for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_cmp
        assign vs1_hit[i] = byp.byp_valid[i] && (byp.byp_vd[i] == vs1_idx);
        assign vs2_hit[i] = byp.byp_valid[i] && (byp.byp_vd[i] == vs2_idx);
        assign vd_hit[i]  = byp.byp_valid[i] && (byp.byp_vd[i] == vd_idx);
        assign v0_hit[i]  = byp.byp_valid[i] && (byp.byp_vd[i] == '0);
    end

    assign stall = youngest_pending(vs1_hit, byp.byp_done) ||
                   youngest_pending(vs2_hit, byp.byp_done) ||
                   youngest_pending(vd_hit, byp.byp_done)  ||
                   youngest_pending(v0_hit, byp.byp_done);

endmodule

// ==== rob/rvv_rob.sv ====
/*
 * vector reorder buffer: allocation, writeback, in-order retire to the VRF
 * and an age-ordered bypass view for dispatch
 */
module rvv_rob (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc_valid,
    input  rvv_disp_pkg::vreg_idx_t  alloc_vd,
    input  rvv_disp_pkg::vl_t        alloc_vl,
    input  rvv_disp_pkg::byte_mask_t alloc_mask,
    input  logic                     alloc_vta,
    input  logic                     alloc_vma,
    output logic                     alloc_ready,
    output rvv_disp_pkg::rob_idx_t   alloc_idx,
    input  logic                     wb_valid,
    input  rvv_disp_pkg::rob_idx_t   wb_idx,
    input  rvv_disp_pkg::vreg_t      wb_data,
    rob_byp_if.rob                   byp,
    vrf_wr_if.src                    ret
);
    import rvv_disp_pkg::*;

    rob_vec_t               ent_valid;
    rob_vec_t               ent_done;
    rob_vec_t               ent_ina_one;
    rob_vec_t               ent_tail_one;
    vreg_idx_t              ent_vd [ROB_DEPTH];
    vreg_t                  ent_data [ROB_DEPTH];
    byte_type_t [VLENB-1:0] ent_type [ROB_DEPTH];

    rob_idx_t                   head;
    rob_idx_t                   tail;
    logic [$clog2(ROB_DEPTH):0] count;
    byte_type_t [VLENB-1:0]     new_type;
    logic                       do_alloc;
    logic                       do_retire;

    assign alloc_ready = (count != ROB_DEPTH);
    assign alloc_idx   = tail;
    assign do_alloc    = alloc_valid && alloc_ready;

    // classify each destination byte at allocation
    always_comb begin
        for (int j = 0; j < VLENB; j++) begin
            if (j >= alloc_vl)
                new_type[j] = TAIL;
            else if (alloc_mask[j])
                new_type[j] = BODY_ACTIVE;
            else
                new_type[j] = BODY_INACTIVE;
        end
    end

    // head retires as soon as it is done
    assign ret.req   = ent_valid[head] && ent_done[head];
    assign ret.addr  = ent_vd[head];
    assign ret.data  = ent_data[head];
    assign do_retire = ret.req && ret.gnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_done  <= '0;
        end else begin
            if (do_alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;
                tail            <= tail + rob_idx_t'(1);
            end
            if (wb_valid)
                ent_done[wb_idx] <= 1'b1;
            if (do_retire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + rob_idx_t'(1);
            end
            case ({do_alloc, do_retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            ent_vd[tail]       <= alloc_vd;
            ent_type[tail]     <= new_type;
            ent_ina_one[tail]  <= alloc_vma;
            ent_tail_one[tail] <= alloc_vta;
        end
        if (wb_valid)
            ent_data[wb_idx] <= wb_data;
    end

    // rotate from head so index 0 is the oldest entry
    for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_age
        localparam rob_idx_t OFS = rob_idx_t'(i);
        rob_idx_t slot;

        assign slot                    = head + OFS;
        assign byp.byp_valid[i]        = ent_valid[slot];
        assign byp.byp_done[i]         = ent_done[slot];
        assign byp.byp_vd[i]           = ent_vd[slot];
        assign byp.byp_data[i]         = ent_data[slot];
        assign byp.byp_type[i]         = ent_type[slot];
        assign byp.byp_inactive_one[i] = ent_ina_one[slot];
        assign byp.byp_tail_one[i]     = ent_tail_one[slot];
    end

endmodule

// ==== common/rvv_if.sv ====
/*
 * backend interfaces: ROB bypass view, VRF read ports, VRF write request
 */

// age-ordered ROB entries, index 0 is the oldest
interface rob_byp_if;
    import rvv_disp_pkg::*;

    rob_vec_t                    byp_valid;
    rob_vec_t                    byp_done;
    vreg_idx_t                   byp_vd [ROB_DEPTH];
    vreg_t                       byp_data [ROB_DEPTH];
    byte_type_t [VLENB-1:0]      byp_type [ROB_DEPTH];
    rob_vec_t                    byp_inactive_one;   // vma
    rob_vec_t                    byp_tail_one;       // vta

    modport rob  (output byp_valid, byp_done, byp_vd, byp_data, byp_type,
                  byp_inactive_one, byp_tail_one);
    modport disp (input  byp_valid, byp_done, byp_vd, byp_data, byp_type,
                  byp_inactive_one, byp_tail_one);
endinterface

// four combinational read ports, v0 always reads register 0
interface vrf_rd_if;
    import rvv_disp_pkg::*;

    vreg_idx_t vs1_idx, vs2_idx, vd_idx, v0_idx;
    vreg_t     vs1_data, vs2_data, vd_data, v0_data;

    modport disp (output vs1_idx, vs2_idx, vd_idx, v0_idx,
                  input  vs1_data, vs2_data, vd_data, v0_data);
    modport vrf  (input  vs1_idx, vs2_idx, vd_idx, v0_idx,
                  output vs1_data, vs2_data, vd_data, v0_data);
endinterface

// write request held until gnt is seen at an edge
interface vrf_wr_if;
    import rvv_disp_pkg::*;

    logic      req;
    vreg_idx_t addr;
    vreg_t     data;
    logic      gnt;

    modport src (output req, addr, data, input gnt);
    modport arb (input req, addr, data, output gnt);
endinterface

// ==== common/rvv_disp_pkg.sv ====
/*
 * vector backend shared definitions
 * widths, ROB depth and byte classification codes
 */
package rvv_disp_pkg;

    localparam int VLENB     = 4;          // bytes per vector register
    localparam int VLEN      = VLENB * 8;
    localparam int ROB_DEPTH = 8;          // bypass select assumes 8
    localparam int NUM_VREG  = 32;

    // one vector register value
    typedef logic [VLEN-1:0] vreg_t;

    // architectural register number
    typedef logic [$clog2(NUM_VREG)-1:0] vreg_idx_t;

    // ROB slot number and per-entry flags
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [ROB_DEPTH-1:0]         rob_vec_t;

    // per-byte enable coming with an allocation
    typedef logic [VLENB-1:0] byte_mask_t;

    // vector length in bytes, 0..VLENB
    typedef logic [$clog2(VLENB):0] vl_t;

    // classification of one destination byte
    typedef logic [1:0] byte_type_t;

    localparam byte_type_t BODY_ACTIVE   = 2'd0;
    localparam byte_type_t BODY_INACTIVE = 2'd1;  // masked off
    localparam byte_type_t TAIL          = 2'd2;  // at or beyond vl

endpackage
